// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_ex_mem_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only --timing
SOURCES    := $(wildcard design/*.sv sim/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The simulator's exit status carries pass or fail
run: build
	$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/ex_mem_reg.sv ====
// EX/MEM pipeline register
// Captures the execute bundle on work, holds on stop and
// loads a bubble on refresh or the spare flow code

`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module ex_mem_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::flow_e   flow_i,
    input  rv_pkg::ex_mem_t d_i,
    output rv_pkg::ex_mem_t q_o
);

    // Empty slot, also the reset state
    localparam rv_pkg::ex_mem_t RST_VAL = '{
        res_op:  rv_pkg::RESCTRL_NONE,
        pc:      `RST_PC,
        default: '0
    };

    rv_pkg::ex_mem_t bubble;

    // Refresh clears everything except the ALU result
    always_comb begin
        bubble         = RST_VAL;
        bubble.alu_res = q_o.alu_res;
    end

    // ----------------------------------------
    // Flow-controlled capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= RST_VAL;
        end else begin
            case (flow_i)
                rv_pkg::FLOW_WORK: begin
                    q_o <= d_i;
                end
                rv_pkg::FLOW_STOP: begin
                    q_o <= q_o;
                end
                rv_pkg::FLOW_REFRESH: begin
                    q_o <= bubble;
                end
                // Unused code behaves as refresh
                default: begin
                    q_o <= bubble;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_mem_top.sv ====
// Execute-to-memory slice top level
// Execute unit, EX/MEM register and memory access stage in series

`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module ex_mem_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rv_pkg::flow_e               flow_i,
    input  rv_pkg::ex_in_t              ex_i,
    output logic                        instmem_access_o,
    output rv_pkg::wb_t                 wb_o,
    output logic                        csr_wr_en_o,
    output logic [`CSR_ADDR_WIDTH-1:0]  csr_wr_addr_o,
    output logic [`CPU_WIDTH-1:0]       csr_data_o
);

    rv_pkg::ex_mem_t ex_bundle;
    rv_pkg::ex_mem_t mem_bundle;
    logic            hold;

    // Stall level seen by the memory stage
    assign hold = (flow_i == rv_pkg::FLOW_STOP);

    exec_unit u_exec_unit (
        .ex_i             (ex_i),
        .ex_o             (ex_bundle),
        .instmem_access_o (instmem_access_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .flow_i (flow_i),
        .d_i    (ex_bundle),
        .q_o    (mem_bundle)
    );

    mem_access u_mem_access (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold_i        (hold),
        .m_i           (mem_bundle),
        .wb_o          (wb_o),
        .csr_wr_en_o   (csr_wr_en_o),
        .csr_wr_addr_o (csr_wr_addr_o),
        .csr_data_o    (csr_data_o)
    );

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
// Execute unit
// Decodes the instruction word, selects operand B, runs the ALU and
// builds the bundle for the EX/MEM register. Also flags loads and
// stores that fall into the instruction-memory region.

`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module exec_unit (
    input  rv_pkg::ex_in_t  ex_i,
    output rv_pkg::ex_mem_t ex_o,
    output logic            instmem_access_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   alt_bit;
    logic                   is_arith;
    logic                   op_sub;
    logic [`CPU_WIDTH-1:0]  imm_i_ext;
    logic [`CPU_WIDTH-1:0]  imm_s_ext;
    logic [`CPU_WIDTH-1:0]  op_b;
    logic [4:0]             shamt;
    logic [`CPU_WIDTH-1:0]  sum;
    logic [`CPU_WIDTH-1:0]  alu_res;
    rv_pkg::resctrl_e       res_op;
    logic                   is_store;

    // ----------------------------------------
    // Decode through the union views
    assign opcode  = ex_i.inst.r_fmt.opcode;
    assign funct3  = ex_i.inst.r_fmt.funct3;
    // Same bit as imm12[10] in the I view, picks sra for OP_IMM too
    assign alt_bit = ex_i.inst.r_fmt.funct7[5];

    assign imm_i_ext = {{(`CPU_WIDTH-12){ex_i.inst.i_fmt.imm12[11]}},
                        ex_i.inst.i_fmt.imm12};
    assign imm_s_ext = {{(`CPU_WIDTH-12){ex_i.inst.s_fmt.imm_hi[6]}},
                        ex_i.inst.s_fmt.imm_hi, ex_i.inst.s_fmt.imm_lo};

    assign is_arith = (opcode == rv_pkg::OPC_OP) || (opcode == rv_pkg::OPC_OP_IMM);
    assign is_store = (opcode == rv_pkg::OPC_STORE);

    // Operand B source
    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP:    op_b = ex_i.rs2_data;
            rv_pkg::OPC_STORE: op_b = imm_s_ext;
            default:           op_b = imm_i_ext;
        endcase
    end

    // ----------------------------------------
    // ALU
    assign shamt  = op_b[4:0];
    // No subtract form exists for immediates
    assign op_sub = (opcode == rv_pkg::OPC_OP) && alt_bit && (funct3 == 3'b000);
    assign sum    = op_sub ? (ex_i.rs1_data - op_b) : (ex_i.rs1_data + op_b);

    always_comb begin
        if (opcode == rv_pkg::OPC_SYSTEM) begin
            alu_res = ex_i.rs1_data;
        end else if (is_arith) begin
            case (funct3)
                3'b001:  alu_res = ex_i.rs1_data << shamt;
                3'b010:  alu_res = {{(`CPU_WIDTH-1){1'b0}},
                                    $signed(ex_i.rs1_data) < $signed(op_b)};
                3'b100:  alu_res = ex_i.rs1_data ^ op_b;
                3'b101: begin
                    if (alt_bit) begin
                        alu_res = $signed(ex_i.rs1_data) >>> shamt;
                    end else begin
                        alu_res = ex_i.rs1_data >> shamt;
                    end
                end
                3'b110:  alu_res = ex_i.rs1_data | op_b;
                3'b111:  alu_res = ex_i.rs1_data & op_b;
                default: alu_res = sum;
            endcase
        end else begin
            // Address generation for loads and stores
            alu_res = sum;
        end
    end

    // Result routing
    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP,
            rv_pkg::OPC_OP_IMM: res_op = rv_pkg::RESCTRL_REG;
            rv_pkg::OPC_LOAD,
            rv_pkg::OPC_STORE:  res_op = rv_pkg::RESCTRL_MEM;
            rv_pkg::OPC_SYSTEM: res_op = rv_pkg::RESCTRL_CSR;
            default:            res_op = rv_pkg::RESCTRL_NONE;
        endcase
    end

    // ----------------------------------------
    // Bundle for the EX/MEM register
    always_comb begin
        ex_o.rs2_data    = ex_i.rs2_data;
        ex_o.inst        = ex_i.inst;
        ex_o.pc          = ex_i.pc;
        ex_o.res_op      = res_op;
        ex_o.alu_res     = alu_res;
        ex_o.reg_wr_en   = ex_i.reg_wr_en & ~is_store;
        ex_o.reg_wr_addr = ex_i.reg_wr_addr;
        ex_o.csr_wr_en   = ex_i.csr_wr_en;
        ex_o.csr_wr_addr = ex_i.csr_wr_addr;
        ex_o.csr_rd_data = ex_i.csr_rd_data;
        ex_o.is_store    = is_store;
    end

    // Fetch must stall when data traffic hits instruction memory
    assign instmem_access_o = (res_op == rv_pkg::RESCTRL_MEM) &&
                              (alu_res[`CPU_WIDTH-1 -: 4] == `INSTMEM_NIBBLE);

endmodule

`default_nettype wire

// ==== design/mem_access.sv ====
// Memory access stage
// Word loads and stores on the data RAM, writeback selection
// between ALU result, load data and CSR read data, and the
// CSR write port

`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module mem_access (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        hold_i,
    input  rv_pkg::ex_mem_t             m_i,
    output rv_pkg::wb_t                 wb_o,
    output logic                        csr_wr_en_o,
    output logic [`CSR_ADDR_WIDTH-1:0]  csr_wr_addr_o,
    output logic [`CPU_WIDTH-1:0]       csr_data_o
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`CPU_WIDTH-1:0] dmem [`DMEM_WORDS];

    logic [DMEM_AW-1:0]    word_idx;
    logic [`CPU_WIDTH-1:0] rd_word;
    logic                  is_load;
    logic                  store_we;
    logic                  store_done_q;

    // Word address, byte offset dropped
    assign word_idx = m_i.alu_res[DMEM_AW+1:2];
    assign is_load  = (m_i.res_op == rv_pkg::RESCTRL_MEM) && !m_i.is_store;

    // ----------------------------------------
    // Store path
    // A stalled store stays in the register, so only its first
    // cycle may write
    assign store_we = m_i.is_store && !store_done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_done_q <= 1'b0;
        end else if (hold_i) begin
            store_done_q <= store_done_q | store_we;
        end else begin
            store_done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_we) begin
            dmem[word_idx] <= m_i.rs2_data;
        end
    end

    // Asynchronous read, load data ready in the same cycle
    assign rd_word = dmem[word_idx];

    // ----------------------------------------
    // Writeback select
    always_comb begin
        wb_o.wr_en   = m_i.reg_wr_en && (m_i.res_op != rv_pkg::RESCTRL_NONE);
        wb_o.wr_addr = m_i.reg_wr_addr;
        if (is_load) begin
            wb_o.wr_data = rd_word;
        end else if (m_i.res_op == rv_pkg::RESCTRL_CSR) begin
            wb_o.wr_data = m_i.csr_rd_data;
        end else begin
            wb_o.wr_data = m_i.alu_res;
        end
    end

    // CSR write port, rs1 arrives through the ALU
    assign csr_wr_en_o   = m_i.csr_wr_en && (m_i.res_op == rv_pkg::RESCTRL_CSR);
    assign csr_wr_addr_o = m_i.csr_wr_addr;
    assign csr_data_o    = m_i.alu_res;

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
// Shared types for the execute-to-memory slice
// Flow and result-control codes, instruction word views, opcodes
// and the bundles passed between the execute and memory stages

`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    typedef enum logic [`FLOW_WIDTH-1:0] {
        FLOW_WORK    = `FLOW_CODE_WORK,
        FLOW_STOP    = `FLOW_CODE_STOP,
        FLOW_REFRESH = `FLOW_CODE_REFR
    } flow_e;

    typedef enum logic [`RESCTRL_WIDTH-1:0] {
        RESCTRL_REG  = `RESCTRL_CODE_REG,
        RESCTRL_MEM  = `RESCTRL_CODE_MEM,
        RESCTRL_CSR  = `RESCTRL_CODE_CSR,
        RESCTRL_NONE = `RESCTRL_CODE_NONE
    } resctrl_e;

    // Major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ----------------------------------------
    // Instruction word views, MSB first
    typedef struct packed {
        logic [6:0]                  funct7;
        logic [`REG_ADDR_WIDTH-1:0]  rs2;
        logic [`REG_ADDR_WIDTH-1:0]  rs1;
        logic [2:0]                  funct3;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [6:0]                  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                 imm12;
        logic [`REG_ADDR_WIDTH-1:0]  rs1;
        logic [2:0]                  funct3;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [6:0]                  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                  imm_hi;
        logic [`REG_ADDR_WIDTH-1:0]  rs2;
        logic [`REG_ADDR_WIDTH-1:0]  rs1;
        logic [2:0]                  funct3;
        logic [4:0]                  imm_lo;
        logic [6:0]                  opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_u;

    // ----------------------------------------
    // Stage bundles
    typedef struct packed {
        logic [`CPU_WIDTH-1:0]       rs1_data;
        logic [`CPU_WIDTH-1:0]       rs2_data;
        inst_u                       inst;
        logic [`CPU_WIDTH-1:0]       pc;
        logic                        reg_wr_en;
        logic [`REG_ADDR_WIDTH-1:0]  reg_wr_addr;
        logic                        csr_wr_en;
        logic [`CSR_ADDR_WIDTH-1:0]  csr_wr_addr;
        logic [`CPU_WIDTH-1:0]       csr_rd_data;
    } ex_in_t;

    typedef struct packed {
        logic [`CPU_WIDTH-1:0]       rs2_data;
        inst_u                       inst;
        logic [`CPU_WIDTH-1:0]       pc;
        resctrl_e                    res_op;
        logic [`CPU_WIDTH-1:0]       alu_res;
        logic                        reg_wr_en;
        logic [`REG_ADDR_WIDTH-1:0]  reg_wr_addr;
        logic                        csr_wr_en;
        logic [`CSR_ADDR_WIDTH-1:0]  csr_wr_addr;
        logic [`CPU_WIDTH-1:0]       csr_rd_data;
        logic                        is_store;
    } ex_mem_t;

    typedef struct packed {
        logic                        wr_en;
        logic [`REG_ADDR_WIDTH-1:0]  wr_addr;
        logic [`CPU_WIDTH-1:0]       wr_data;
    } wb_t;

endpackage

`default_nettype wire

// ==== include/rv_settings.svh ====
// Execute-to-memory slice settings
// Data and address widths, data RAM depth, pipeline flow codes,
// result-control codes and the reset values of the EX/MEM register

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath and register file geometry
`define CPU_WIDTH        32
`define REG_ADDR_WIDTH   5
`define CSR_ADDR_WIDTH   12

// Data RAM depth in words, a power of two
`define DMEM_WORDS       256

// Top address nibble of the instruction region
`define INSTMEM_NIBBLE   4'h0

// ----------------------------------------
// Pipeline flow command
`define FLOW_WIDTH       2
`define FLOW_CODE_WORK   2'b00
`define FLOW_CODE_STOP   2'b01
`define FLOW_CODE_REFR   2'b10

// ----------------------------------------
// Result control and reset values
`define RESCTRL_WIDTH    2
`define RESCTRL_CODE_REG  2'b00
`define RESCTRL_CODE_MEM  2'b01
`define RESCTRL_CODE_CSR  2'b10
`define RESCTRL_CODE_NONE 2'b11
`define RST_PC           32'h0000_0000

`endif

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a few cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the capture edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_ex_mem_top.sv ====
// Testbench for the execute-to-memory slice
// Directed tests for ALU results, word loads and stores, stall and
// bubble handling, CSR pass-through and the instruction-memory flag

`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module tb_ex_mem_top;

    localparam int          CLK_PERIOD    = 100;
    localparam int          RESET_TIMEOUT = 20;
    localparam int          WATCHDOG_NS   = 200_000;
    localparam int          N_ARITH       = 40;
    localparam int          N_FLAG        = 12;
    localparam int          STALL_CYCLES  = 3;
    localparam logic [4:0]  STORE_RD      = 5'd7;
    localparam logic [31:0] LFSR_SEED     = 32'hd696_e2f0;

    logic                        clk;
    logic                        rst_n;
    rv_pkg::flow_e               flow;
    rv_pkg::ex_in_t              ex_in;
    logic                        instmem_access;
    rv_pkg::wb_t                 wb;
    logic                        csr_wr_en;
    logic [`CSR_ADDR_WIDTH-1:0]  csr_wr_addr;
    logic [`CPU_WIDTH-1:0]       csr_data;
    logic [31:0]                 lfsr_state;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_mem_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .flow_i           (flow),
        .ex_i             (ex_in),
        .instmem_access_o (instmem_access),
        .wb_o             (wb),
        .csr_wr_en_o      (csr_wr_en),
        .csr_wr_addr_o    (csr_wr_addr),
        .csr_data_o       (csr_data)
    );

    // ----------------------------------------
    // Stimulus and reference helpers

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[31]};
        end
        return v;
    endfunction

    function automatic logic [`CPU_WIDTH-1:0] sext12(input logic [11:0] imm);
        return {{(`CPU_WIDTH-12){imm[11]}}, imm};
    endfunction

    // Integer ops of OP and OP_IMM
    function automatic logic [`CPU_WIDTH-1:0] alu_expect(
        input logic                  is_reg,
        input logic [2:0]            f3,
        input logic                  alt,
        input logic [`CPU_WIDTH-1:0] a,
        input logic [`CPU_WIDTH-1:0] b
    );
        logic [4:0]            sh;
        logic [`CPU_WIDTH-1:0] r;
        sh = b[4:0];
        r  = '0;
        case (f3)
            3'd0: r = (is_reg && alt) ? (a - b) : (a + b);
            3'd1: r = a << sh;
            3'd2: r[0] = $signed(a) < $signed(b);
            3'd4: r = a ^ b;
            3'd5: begin
                r = a >> sh;
                // Arithmetic form fills the vacated bits with the sign
                if (alt && a[`CPU_WIDTH-1]) begin
                    r = r | ~({`CPU_WIDTH{1'b1}} >> sh);
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic rv_pkg::ex_in_t load_inst(input logic [`CPU_WIDTH-1:0] base,
                                                 input logic [11:0] imm,
                                                 input logic [4:0] rd,
                                                 input logic wr_en);
        rv_pkg::ex_in_t in;
        in = '0;
        in.inst.i_fmt  = '{imm12: imm, rs1: 5'd1, funct3: 3'b010, rd: rd,
                           opcode: rv_pkg::OPC_LOAD};
        in.rs1_data    = base;
        in.reg_wr_en   = wr_en;
        in.reg_wr_addr = rd;
        return in;
    endfunction

    // Register write requested so that its clearing shows
    function automatic rv_pkg::ex_in_t store_inst(input logic [`CPU_WIDTH-1:0] base,
                                                  input logic [11:0] imm,
                                                  input logic [`CPU_WIDTH-1:0] data);
        rv_pkg::ex_in_t in;
        in = '0;
        in.inst.s_fmt  = '{imm_hi: imm[11:5], rs2: 5'd2, rs1: 5'd1, funct3: 3'b010,
                           imm_lo: imm[4:0], opcode: rv_pkg::OPC_STORE};
        in.rs1_data    = base;
        in.rs2_data    = data;
        in.reg_wr_en   = 1'b1;
        in.reg_wr_addr = STORE_RD;
        return in;
    endfunction

    function automatic rv_pkg::ex_in_t system_inst(input logic [`CPU_WIDTH-1:0] rs1_val,
                                                   input logic [`CPU_WIDTH-1:0] csr_rd,
                                                   input logic [`CSR_ADDR_WIDTH-1:0] csr_addr,
                                                   input logic [4:0] rd);
        rv_pkg::ex_in_t in;
        in = '0;
        in.inst.i_fmt  = '{imm12: csr_addr, rs1: 5'd1, funct3: 3'b001, rd: rd,
                           opcode: rv_pkg::OPC_SYSTEM};
        in.rs1_data    = rs1_val;
        in.reg_wr_en   = 1'b1;
        in.reg_wr_addr = rd;
        in.csr_wr_en   = 1'b1;
        in.csr_wr_addr = csr_addr;
        in.csr_rd_data = csr_rd;
        return in;
    endfunction

    function automatic rv_pkg::wb_t wb_value(input logic en,
                                             input logic [`REG_ADDR_WIDTH-1:0] addr,
                                             input logic [`CPU_WIDTH-1:0] data);
        rv_pkg::wb_t w;
        w.wr_en   = en;
        w.wr_addr = addr;
        w.wr_data = data;
        return w;
    endfunction

    // ----------------------------------------
    // Compare tasks

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_wb(input string what, input rv_pkg::wb_t exp_wb);
        if (wb !== exp_wb) begin
            $display("FAIL wb_o (%s): expected en=%h addr=%h data=%h, actual en=%h addr=%h data=%h",
                     what, exp_wb.wr_en, exp_wb.wr_addr, exp_wb.wr_data,
                     wb.wr_en, wb.wr_addr, wb.wr_data);
            abort_run();
        end
    endtask

    task automatic check_flag(input string sig, input logic exp_bit, input logic act_bit);
        if (act_bit !== exp_bit) begin
            $display("FAIL %s: expected %h, actual %h", sig, exp_bit, act_bit);
            abort_run();
        end
    endtask

    task automatic check_csr(input logic exp_en,
                             input logic [`CSR_ADDR_WIDTH-1:0] exp_addr,
                             input logic [`CPU_WIDTH-1:0] exp_data);
        if (csr_wr_en !== exp_en || csr_wr_addr !== exp_addr || csr_data !== exp_data) begin
            $display("FAIL csr_wr_en_o/csr_wr_addr_o/csr_data_o: expected %h/%h/%h, actual %h/%h/%h",
                     exp_en, exp_addr, exp_data, csr_wr_en, csr_wr_addr, csr_data);
            abort_run();
        end
    endtask

    // Release is seen at a rising edge, tests start on the next falling one
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
                abort_run();
            end
        end
        @(negedge clk);
    endtask

    // ----------------------------------------
    // Directed tests, each starts and ends on a falling edge

    task automatic after_reset();
        check_flag("wb_o.wr_en", 1'b0, wb.wr_en);
        check_flag("csr_wr_en_o", 1'b0, csr_wr_en);
    endtask

    task automatic random_arith();
        rv_pkg::ex_in_t        in;
        logic                  is_reg;
        logic [2:0]            f3;
        logic                  alt;
        logic [4:0]            rd;
        logic [11:0]           imm;
        logic [`CPU_WIDTH-1:0] b;
        logic [`CPU_WIDTH-1:0] exp_data;
        for (int i = 0; i < N_ARITH; i++) begin
            in          = '0;
            in.rs1_data = rand_bits(32);
            in.rs2_data = rand_bits(32);
            is_reg      = 1'(rand_bits(1));
            f3          = 3'(rand_bits(3));
            // No sltu in this slice
            if (f3 == 3'd3) begin
                f3 = 3'd2;
            end
            rd  = 5'(rand_bits(5));
            alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand_bits(1)) : 1'b0;
            if (is_reg) begin
                in.inst.r_fmt = '{funct7: {1'b0, alt, 5'b0}, rs2: 5'd2, rs1: 5'd1,
                                  funct3: f3, rd: rd, opcode: rv_pkg::OPC_OP};
                b = in.rs2_data;
            end else begin
                // Shift immediates hold shamt and the arithmetic bit
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, alt, 5'b0, 5'(rand_bits(5))};
                end else begin
                    imm = 12'(rand_bits(12));
                end
                in.inst.i_fmt = '{imm12: imm, rs1: 5'd1, funct3: f3, rd: rd,
                                  opcode: rv_pkg::OPC_OP_IMM};
                b   = sext12(imm);
                alt = imm[10];
            end
            in.reg_wr_en   = 1'b1;
            in.reg_wr_addr = rd;
            exp_data = alu_expect(is_reg, f3, alt, in.rs1_data, b);
            ex_in = in;
            flow  = rv_pkg::FLOW_WORK;
            @(negedge clk);
            check_wb("arith", wb_value(1'b1, rd, exp_data));
        end
    endtask

    task automatic store_then_load();
        logic [`CPU_WIDTH-1:0] base;
        logic [`CPU_WIDTH-1:0] addr;
        logic [`CPU_WIDTH-1:0] data;
        logic [11:0]           imm;
        logic [4:0]            rd;
        base       = rand_bits(32);
        base[1:0]  = 2'b00;
        imm        = {10'(rand_bits(10)), 2'b00};
        addr       = base + sext12(imm);
        data       = rand_bits(32);
        rd         = 5'(rand_bits(5));
        ex_in = store_inst(base, imm, data);
        flow  = rv_pkg::FLOW_WORK;
        @(negedge clk);
        // Store result is its address
        check_wb("store", wb_value(1'b0, STORE_RD, addr));
        imm   = {10'(rand_bits(10)), 2'b00};
        ex_in = load_inst(addr - sext12(imm), imm, rd, 1'b1);
        @(negedge clk);
        check_wb("load", wb_value(1'b1, rd, data));
        ex_in = load_inst(addr, 12'h0, rd, 1'b0);
        @(negedge clk);
        check_wb("load without write", wb_value(1'b0, rd, data));
    endtask

    task automatic stall_and_bubble();
        logic [`CPU_WIDTH-1:0] base;
        logic [`CPU_WIDTH-1:0] addr;
        logic [`CPU_WIDTH-1:0] data_a;
        logic [`CPU_WIDTH-1:0] data_b;
        logic [11:0]           imm;
        logic [4:0]            rd;
        rv_pkg::wb_t           held;
        base      = rand_bits(32);
        base[1:0] = 2'b00;
        imm       = {10'(rand_bits(10)), 2'b00};
        addr      = base + sext12(imm);
        data_a    = rand_bits(32);
        data_b    = rand_bits(32);
        rd        = 5'(rand_bits(5));
        held      = wb_value(1'b0, STORE_RD, addr);
        ex_in = store_inst(base, imm, data_a);
        flow  = rv_pkg::FLOW_WORK;
        @(negedge clk);
        check_wb("store before stall", held);

        // Inputs move while the register holds the store
        flow = rv_pkg::FLOW_STOP;
        for (int i = 0; i < STALL_CYCLES; i++) begin
            ex_in = load_inst(rand_bits(32), 12'(rand_bits(12)), 5'(rand_bits(5)), 1'b1);
            @(negedge clk);
            check_wb("stalled", held);
            check_flag("csr_wr_en_o", 1'b0, csr_wr_en);
        end

        // Held store reached the RAM
        flow  = rv_pkg::FLOW_WORK;
        ex_in = load_inst(addr, 12'h0, rd, 1'b1);
        @(negedge clk);
        check_wb("load of held store", wb_value(1'b1, rd, data_a));

        // Later store to the same word wins
        ex_in = store_inst(addr, 12'h0, data_b);
        @(negedge clk);
        check_wb("store after stall", held);
        ex_in = load_inst(addr, 12'h0, rd, 1'b1);
        @(negedge clk);
        check_wb("load after stall", wb_value(1'b1, rd, data_b));

        // Bubble drops a captured CSR write
        ex_in = system_inst(rand_bits(32), rand_bits(32), 12'(rand_bits(12)), rd);
        @(negedge clk);
        check_flag("csr_wr_en_o", 1'b1, csr_wr_en);
        flow = rv_pkg::FLOW_REFRESH;
        @(negedge clk);
        check_flag("wb_o.wr_en", 1'b0, wb.wr_en);
        check_flag("csr_wr_en_o", 1'b0, csr_wr_en);
    endtask

    task automatic csr_passthrough();
        logic [`CPU_WIDTH-1:0]      rs1_val;
        logic [`CPU_WIDTH-1:0]      csr_rd;
        logic [`CSR_ADDR_WIDTH-1:0] csr_addr;
        logic [4:0]                 rd;
        rs1_val  = rand_bits(32);
        csr_rd   = rand_bits(32);
        csr_addr = 12'(rand_bits(12));
        rd       = 5'(rand_bits(5));
        ex_in = system_inst(rs1_val, csr_rd, csr_addr, rd);
        flow  = rv_pkg::FLOW_WORK;
        @(negedge clk);
        check_wb("system", wb_value(1'b1, rd, csr_rd));
        check_csr(1'b1, csr_addr, rs1_val);
    endtask

    task automatic instmem_flag_sweep();
        logic [3:0]            nib;
        logic [`CPU_WIDTH-1:0] base;
        logic [`CPU_WIDTH-1:0] addr;
        logic [11:0]           imm;
        logic                  is_mem;
        logic                  exp_flag;
        // Register stays a bubble so nothing is written
        flow = rv_pkg::FLOW_REFRESH;
        for (int i = 0; i < N_FLAG; i++) begin
            nib    = (i % 2 == 0) ? `INSTMEM_NIBBLE : (4'(rand_bits(4)) | 4'h8);
            base   = {nib, 28'(rand_bits(28))};
            imm    = (i < 6) ? 12'h0 : 12'(rand_bits(12));
            addr   = base + sext12(imm);
            is_mem = (i % 3 != 2);
            if (i % 3 == 0) begin
                ex_in = load_inst(base, imm, 5'd3, 1'b1);
            end else if (i % 3 == 1) begin
                ex_in = store_inst(base, imm, rand_bits(32));
            end else begin
                ex_in = system_inst(base, rand_bits(32), imm, 5'd3);
            end
            exp_flag = is_mem && (addr[`CPU_WIDTH-1 -: 4] == `INSTMEM_NIBBLE);
            #(CLK_PERIOD / 4);
            check_flag("instmem_access_o", exp_flag, instmem_access);
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Run control

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        lfsr_state = LFSR_SEED;
        flow       = rv_pkg::FLOW_REFRESH;
        ex_in      = '0;
        wait_reset_release();
        after_reset();
        random_arith();
        store_then_load();
        stall_and_bubble();
        csr_passthrough();
        instmem_flag_sweep();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
design/rv_pkg.sv
design/exec_unit.sv
design/ex_mem_reg.sv
design/mem_access.sv
design/ex_mem_top.sv
sim/tb_clock_gen.sv
sim/tb_ex_mem_top.sv
